// File: logic/lsu_pkg.sv
`default_nettype none

package lsu_pkg;

    // ----------------------------------------
    // Basic widths
    // ----------------------------------------
    typedef logic [31:0] xlen_t;
    typedef logic [3:0]  strb_t;
    typedef logic [4:0]  reg_idx_t;

    // Major opcodes of the RV32I load and store groups
    localparam logic [6:0] OPC_LOAD  = 7'b0000011;
    localparam logic [6:0] OPC_STORE = 7'b0100011;

    // funct3 access size and sign
    localparam logic [2:0] F3_B  = 3'b000;
    localparam logic [2:0] F3_H  = 3'b001;
    localparam logic [2:0] F3_W  = 3'b010;
    localparam logic [2:0] F3_BU = 3'b100;
    localparam logic [2:0] F3_HU = 3'b101;

    // Tags the response stage can have queued
    localparam int TAG_DEPTH = 2;

    // ----------------------------------------
    // Operations and exceptions
    // ----------------------------------------
    typedef enum logic [3:0] {
        OP_NONE,
        OP_LB,
        OP_LH,
        OP_LW,
        OP_LBU,
        OP_LHU,
        OP_SB,
        OP_SH,
        OP_SW
    } lsu_op_e;

    // RISC-V cause numbers
    typedef enum logic [5:0] {
        EXC_NONE             = 6'd0,
        EXC_MISALIGNED_LOAD  = 6'd4,
        EXC_FAULT_LOAD       = 6'd5,
        EXC_MISALIGNED_STORE = 6'd6,
        EXC_FAULT_STORE      = 6'd7
    } exc_e;

    // Per-access state carried to the response stage
    typedef struct packed {
        xlen_t addr;
        logic  is_load;
        logic  is_signed;
        logic  is_half;
        logic  is_byte;
    } lsu_tag_t;

endpackage

`default_nettype wire

// File: logic/lsu_req_if.sv
`timescale 1ns/1ns
`default_nettype none

// One decoded access, from decode into the issue register
interface lsu_req_if
    import lsu_pkg::*;
();
    logic    valid;
    lsu_op_e op;
    xlen_t   addr;
    xlen_t   wdata;
    strb_t   wstrb;
    logic    misaligned;

    modport source (output valid, op, addr, wdata, wstrb, misaligned);

    modport sink (input valid, op, addr, wdata, wstrb, misaligned);

endinterface

`default_nettype wire

// File: logic/lsu_tag_if.sv
`timescale 1ns/1ns
`default_nettype none

// Tags of issued accesses, oldest first at tag_out
interface lsu_tag_if
    import lsu_pkg::*;
();
    logic     push;
    lsu_tag_t tag_in;
    logic     dummy_ack;
    lsu_tag_t tag_out;
    logic     pop;

    modport producer (output push, tag_in, dummy_ack);

    modport queue (input push, tag_in, pop, output tag_out);

    // Misaligned retirement acts as a response without the bus
    modport consumer (input tag_out, dummy_ack, output pop);

endinterface

`default_nettype wire

// File: logic/lsu_decode.sv
`timescale 1ns/1ns
`default_nettype none

module lsu_decode
    import lsu_pkg::*;
(
    input  logic      opcode_valid_i,
    input  xlen_t     opcode_opcode_i,
    input  xlen_t     opcode_ra_operand_i,
    input  xlen_t     opcode_rb_operand_i,
    lsu_req_if.source req_o
);

    logic [6:0] major_w;
    logic [2:0] funct3_w;
    lsu_op_e    op_r;
    logic       valid_w;
    logic       is_store_w;
    xlen_t      imm_i_w;
    xlen_t      imm_s_w;
    xlen_t      addr_w;
    logic       misaligned_r;
    xlen_t      wdata_r;
    strb_t      wstrb_r;

    assign major_w  = opcode_opcode_i[6:0];
    assign funct3_w = opcode_opcode_i[14:12];

    // ----------------------------------------
    // Operation decode
    // ----------------------------------------
    always_comb
    begin
        op_r = OP_NONE;
        if (major_w == OPC_LOAD)
        begin
            case (funct3_w)
                F3_B:    op_r = OP_LB;
                F3_H:    op_r = OP_LH;
                F3_W:    op_r = OP_LW;
                F3_BU:   op_r = OP_LBU;
                F3_HU:   op_r = OP_LHU;
                default: op_r = OP_NONE;
            endcase
        end
        else if (major_w == OPC_STORE)
        begin
            case (funct3_w)
                F3_B:    op_r = OP_SB;
                F3_H:    op_r = OP_SH;
                F3_W:    op_r = OP_SW;
                default: op_r = OP_NONE;
            endcase
        end
    end

    assign valid_w    = opcode_valid_i && (op_r != OP_NONE);
    assign is_store_w = (op_r == OP_SB) || (op_r == OP_SH) || (op_r == OP_SW);

    // ----------------------------------------
    // Address generation
    // ----------------------------------------
    assign imm_i_w = {{20{opcode_opcode_i[31]}}, opcode_opcode_i[31:20]};
    assign imm_s_w = {{20{opcode_opcode_i[31]}}, opcode_opcode_i[31:25], opcode_opcode_i[11:7]};
    assign addr_w  = opcode_ra_operand_i + (is_store_w ? imm_s_w : imm_i_w);

    // Words need a 4-byte boundary, halfwords an even address
    always_comb
    begin
        case (op_r)
            OP_LW, OP_SW:         misaligned_r = (addr_w[1:0] != 2'b00);
            OP_LH, OP_LHU, OP_SH: misaligned_r = addr_w[0];
            default:              misaligned_r = 1'b0;
        endcase
    end

    // ----------------------------------------
    // Store lane steering
    // ----------------------------------------
    always_comb
    begin
        wdata_r = opcode_rb_operand_i;
        wstrb_r = 4'b0000;
        case (op_r)
            OP_SB:
            begin
                wdata_r = {4{opcode_rb_operand_i[7:0]}};
                wstrb_r = 4'b0001 << addr_w[1:0];
            end
            OP_SH:
            begin
                wdata_r = {2{opcode_rb_operand_i[15:0]}};
                wstrb_r = addr_w[1] ? 4'b1100 : 4'b0011;
            end
            OP_SW:
                wstrb_r = 4'b1111;
            default:
                wstrb_r = 4'b0000;
        endcase

        // No bus write for a bubble or a misaligned store
        if (!valid_w || misaligned_r)
            wstrb_r = 4'b0000;
    end

    assign req_o.valid      = valid_w;
    assign req_o.op         = op_r;
    assign req_o.addr       = addr_w;
    assign req_o.wdata      = wdata_r;
    assign req_o.wstrb      = wstrb_r;
    assign req_o.misaligned = valid_w && misaligned_r;

endmodule

`default_nettype wire

// File: logic/lsu_issue.sv
`timescale 1ns/1ns
`default_nettype none

module lsu_issue
    import lsu_pkg::*;
(
    input  logic         clk_i,
    input  logic         rst_i,
    lsu_req_if.sink      req_i,
    output xlen_t        mem_addr_o,
    output xlen_t        mem_data_wr_o,
    output logic         mem_rd_o,
    output strb_t        mem_wr_o,
    input  logic         mem_accept_i,
    input  logic         mem_ack_i,
    input  logic         mem_error_i,
    output logic         stall_o,
    lsu_tag_if.producer  tag_o
);

    // E1 request register
    logic    rd_q;
    strb_t   wr_q;
    logic    mis_e1_q;
    xlen_t   addr_q;
    xlen_t   wdata_q;
    lsu_op_e op_q;

    logic     pending_q;
    logic     mis_e2_q;
    logic     req_load_w;
    logic     delay_w;
    logic     squash_w;
    logic     mask_w;
    logic     req_w;
    logic     issue_w;
    logic     busy_e1_w;
    logic     dummy_go_w;
    logic     load_en_w;
    lsu_tag_t tag_w;

    // ----------------------------------------
    // Outstanding access tracking
    // ----------------------------------------
    assign delay_w  = pending_q && !mem_ack_i;
    assign squash_w = (mem_ack_i && mem_error_i) || mis_e2_q;
    assign mask_w   = delay_w || squash_w;

    assign mem_rd_o  = rd_q && !mask_w;
    assign mem_wr_o  = wr_q & ~{4{mask_w}};
    assign req_w     = mem_rd_o || (mem_wr_o != 4'b0000);
    assign issue_w   = req_w && mem_accept_i;
    assign busy_e1_w = rd_q || (wr_q != 4'b0000) || mis_e1_q;

    // Misaligned access moves on to its dummy response
    assign dummy_go_w = mis_e1_q && !delay_w && !squash_w;

    assign load_en_w = !squash_w && !(busy_e1_w && delay_w) && !(req_w && !mem_accept_i);

    always_ff @(posedge clk_i or posedge rst_i)
    begin
        if (rst_i)
        begin
            pending_q <= 1'b0;
            mis_e2_q  <= 1'b0;
        end
        else
        begin
            if (issue_w)
                pending_q <= 1'b1;
            else if (mem_ack_i)
                pending_q <= 1'b0;
            mis_e2_q <= dummy_go_w;
        end
    end

    // ----------------------------------------
    // E1 register
    // ----------------------------------------
    assign req_load_w = req_i.op inside {OP_LB, OP_LH, OP_LW, OP_LBU, OP_LHU};

    always_ff @(posedge clk_i or posedge rst_i)
    begin
        if (rst_i)
        begin
            rd_q     <= 1'b0;
            wr_q     <= 4'b0000;
            mis_e1_q <= 1'b0;
        end
        else if (squash_w)
        begin
            // Exception on its way, drop the follower
            rd_q     <= 1'b0;
            wr_q     <= 4'b0000;
            mis_e1_q <= 1'b0;
        end
        else if (load_en_w)
        begin
            rd_q     <= req_i.valid && req_load_w && !req_i.misaligned;
            wr_q     <= req_i.wstrb;
            mis_e1_q <= req_i.misaligned;
        end
    end

    always_ff @(posedge clk_i)
    begin
        if (load_en_w)
        begin
            addr_q  <= req_i.addr;
            wdata_q <= req_i.wdata;
            op_q    <= req_i.op;
        end
    end

    assign mem_addr_o    = {addr_q[31:2], 2'b00};
    assign mem_data_wr_o = wdata_q;

    // Hold the core while a new request cannot move
    assign stall_o = (req_w && !mem_accept_i) || (busy_e1_w && delay_w) || (mis_e1_q && !squash_w);

    // ----------------------------------------
    // Response tag
    // ----------------------------------------
    always_comb
    begin
        tag_w.addr      = addr_q;
        tag_w.is_load   = op_q inside {OP_LB, OP_LH, OP_LW, OP_LBU, OP_LHU};
        tag_w.is_signed = op_q inside {OP_LB, OP_LH, OP_LW};
        tag_w.is_half   = op_q inside {OP_LH, OP_LHU, OP_SH};
        tag_w.is_byte   = op_q inside {OP_LB, OP_LBU, OP_SB};
    end

    assign tag_o.push      = issue_w || dummy_go_w;
    assign tag_o.tag_in    = tag_w;
    assign tag_o.dummy_ack = mis_e2_q;

endmodule

`default_nettype wire

// File: logic/lsu_tag_fifo.sv
`timescale 1ns/1ns
`default_nettype none

module lsu_tag_fifo
    import lsu_pkg::*;
#(
    parameter int DEPTH = TAG_DEPTH
)
(
    input  logic      clk_i,
    input  logic      rst_i,
    lsu_tag_if.queue  q_io
);

    typedef logic [$clog2(DEPTH)-1:0] ptr_t;
    typedef logic [$clog2(DEPTH):0]   cnt_t;

    lsu_tag_t ram_q [DEPTH];
    ptr_t     rd_ptr_q;
    ptr_t     wr_ptr_q;
    cnt_t     count_q;
    logic     do_push_w;
    logic     do_pop_w;

    assign do_push_w = q_io.push && (count_q != cnt_t'(DEPTH));
    assign do_pop_w  = q_io.pop && (count_q != '0);

    // Tag storage
    always_ff @(posedge clk_i)
    begin
        if (do_push_w)
            ram_q[wr_ptr_q] <= q_io.tag_in;
    end

    always_ff @(posedge clk_i or posedge rst_i)
    begin
        if (rst_i)
        begin
            rd_ptr_q <= '0;
            wr_ptr_q <= '0;
            count_q  <= '0;
        end
        else
        begin
            if (do_push_w)
                wr_ptr_q <= wr_ptr_q + ptr_t'(1);
            if (do_pop_w)
                rd_ptr_q <= rd_ptr_q + ptr_t'(1);

            if (do_push_w && !do_pop_w)
                count_q <= count_q + cnt_t'(1);
            else if (!do_push_w && do_pop_w)
                count_q <= count_q - cnt_t'(1);
        end
    end

    assign q_io.tag_out = ram_q[rd_ptr_q];

endmodule

`default_nettype wire

// File: logic/lsu_resp.sv
`timescale 1ns/1ns
`default_nettype none

module lsu_resp
    import lsu_pkg::*;
(
    input  logic         mem_ack_i,
    input  logic         mem_error_i,
    input  xlen_t        mem_data_rd_i,
    lsu_tag_if.consumer  tag_i,
    output logic         writeback_valid_o,
    output xlen_t        writeback_value_o,
    output exc_e         writeback_exception_o
);

    lsu_tag_t tag_w;
    logic     bus_err_w;
    xlen_t    lane_w;
    xlen_t    value_r;
    exc_e     exc_r;

    assign tag_w     = tag_i.tag_out;
    assign bus_err_w = mem_ack_i && mem_error_i;

    // Addressed byte or halfword moved down to bit 0
    assign lane_w = mem_data_rd_i >> {tag_w.addr[1:0], 3'b000};

    always_comb
    begin
        value_r = '0;
        if (bus_err_w || tag_i.dummy_ack)
            value_r = tag_w.addr;  // faulting address
        else if (mem_ack_i && tag_w.is_load)
        begin
            if (tag_w.is_byte)
                value_r = {{24{tag_w.is_signed && lane_w[7]}}, lane_w[7:0]};
            else if (tag_w.is_half)
                value_r = {{16{tag_w.is_signed && lane_w[15]}}, lane_w[15:0]};
            else
                value_r = mem_data_rd_i;
        end
    end

    // ----------------------------------------
    // Exception code
    // ----------------------------------------
    always_comb
    begin
        exc_r = EXC_NONE;
        if (tag_i.dummy_ack)
            exc_r = tag_w.is_load ? EXC_MISALIGNED_LOAD : EXC_MISALIGNED_STORE;
        else if (bus_err_w)
            exc_r = tag_w.is_load ? EXC_FAULT_LOAD : EXC_FAULT_STORE;
    end

    assign tag_i.pop             = mem_ack_i || tag_i.dummy_ack;
    assign writeback_valid_o     = mem_ack_i || tag_i.dummy_ack;
    assign writeback_value_o     = value_r;
    assign writeback_exception_o = exc_r;

endmodule

`default_nettype wire

// File: logic/lsu_top.sv
`timescale 1ns/1ns
`default_nettype none

module lsu_top
    import lsu_pkg::*;
(
    input  logic  clk_i,
    input  logic  rst_i,

    // Core side
    input  logic  opcode_valid_i,
    input  xlen_t opcode_opcode_i,
    input  xlen_t opcode_ra_operand_i,
    input  xlen_t opcode_rb_operand_i,
    output logic  writeback_valid_o,
    output xlen_t writeback_value_o,
    output exc_e  writeback_exception_o,
    output logic  stall_o,

    // Data memory side
    output xlen_t mem_addr_o,
    output xlen_t mem_data_wr_o,
    output logic  mem_rd_o,
    output strb_t mem_wr_o,
    input  logic  mem_accept_i,
    input  logic  mem_ack_i,
    input  logic  mem_error_i,
    input  xlen_t mem_data_rd_i
);

    lsu_req_if req_bus ();
    lsu_tag_if tag_bus ();

    lsu_decode u_decode (
        .opcode_valid_i      (opcode_valid_i),
        .opcode_opcode_i     (opcode_opcode_i),
        .opcode_ra_operand_i (opcode_ra_operand_i),
        .opcode_rb_operand_i (opcode_rb_operand_i),
        .req_o               (req_bus.source)
    );

    lsu_issue u_issue (
        .clk_i         (clk_i),
        .rst_i         (rst_i),
        .req_i         (req_bus.sink),
        .mem_addr_o    (mem_addr_o),
        .mem_data_wr_o (mem_data_wr_o),
        .mem_rd_o      (mem_rd_o),
        .mem_wr_o      (mem_wr_o),
        .mem_accept_i  (mem_accept_i),
        .mem_ack_i     (mem_ack_i),
        .mem_error_i   (mem_error_i),
        .stall_o       (stall_o),
        .tag_o         (tag_bus.producer)
    );

    lsu_tag_fifo #(
        .DEPTH (TAG_DEPTH)
    ) u_tag_fifo (
        .clk_i (clk_i),
        .rst_i (rst_i),
        .q_io  (tag_bus.queue)
    );

    lsu_resp u_resp (
        .mem_ack_i             (mem_ack_i),
        .mem_error_i           (mem_error_i),
        .mem_data_rd_i         (mem_data_rd_i),
        .tag_i                 (tag_bus.consumer),
        .writeback_valid_o     (writeback_valid_o),
        .writeback_value_o     (writeback_value_o),
        .writeback_exception_o (writeback_exception_o)
    );

endmodule

`default_nettype wire

// File: bench/lsu_mem_model.sv
`timescale 1ns/1ns
`default_nettype none

module lsu_mem_model
    import lsu_pkg::*;
(
    input  logic  clk_i,
    input  logic  rst_i,
    input  xlen_t addr_i,
    input  xlen_t data_wr_i,
    input  logic  rd_i,
    input  strb_t wr_i,
    output logic  accept_o,
    output logic  ack_o,
    output logic  error_o,
    output xlen_t data_rd_o
);

    xlen_t       mem_q [256];
    logic        busy_q;
    logic [1:0]  wait_q;
    logic        err_q;
    xlen_t       rdata_q;
    logic [7:0]  idx_w;
    logic        req_w;
    int unsigned delay_v;

    // Every index bit shows up in the stored word
    function automatic xlen_t fill_word(input logic [7:0] idx);
        return {idx ^ 8'ha5, idx + 8'h3c, ~idx, {idx[3:0], idx[7:4]}};
    endfunction

    initial
    begin
        for (int i = 0; i < 256; i++)
            mem_q[i] = fill_word(8'(i));
    end

    assign idx_w = addr_i[9:2];
    assign req_w = rd_i || (wr_i != 4'b0000);

    // ----------------------------------------
    // Accept, delayed acknowledge, error region
    // ----------------------------------------
    always @(posedge clk_i or posedge rst_i)
    begin
        if (rst_i)
        begin
            accept_o  <= 1'b1;
            ack_o     <= 1'b0;
            error_o   <= 1'b0;
            data_rd_o <= '0;
            busy_q    <= 1'b0;
            wait_q    <= 2'd0;
            err_q     <= 1'b0;
            rdata_q   <= '0;
        end
        else
        begin
            ack_o    <= 1'b0;
            error_o  <= 1'b0;
            accept_o <= ($urandom_range(3, 0) != 0);
            if (busy_q)
            begin
                if (wait_q == 2'd0)
                begin
                    ack_o     <= 1'b1;
                    error_o   <= err_q;
                    data_rd_o <= rdata_q;
                    busy_q    <= 1'b0;
                end
                else
                    wait_q <= wait_q - 2'd1;
            end
            if (req_w && accept_o)
            begin
                delay_v = $urandom_range(3, 0);
                if (delay_v == 0)
                begin
                    ack_o     <= 1'b1;
                    error_o   <= addr_i[31];
                    data_rd_o <= mem_q[idx_w];
                end
                else
                begin
                    busy_q  <= 1'b1;
                    wait_q  <= 2'(delay_v - 1);
                    err_q   <= addr_i[31];
                    rdata_q <= mem_q[idx_w];
                end
                // Upper half of the address space is the error region, never written
                if (!addr_i[31])
                begin
                    for (int b = 0; b < 4; b++)
                    begin
                        if (wr_i[b])
                            mem_q[idx_w][8*b +: 8] <= data_wr_i[8*b +: 8];
                    end
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: bench/tb_lsu.sv
`timescale 1ns/1ns
`default_nettype none

module tb_lsu
    import lsu_pkg::*;
();

    typedef struct packed {
        xlen_t value;
        exc_e  exc;
    } expect_t;

    logic  clk_i;
    logic  rst_i;
    logic  opcode_valid_i;
    xlen_t opcode_opcode_i;
    xlen_t opcode_ra_operand_i;
    xlen_t opcode_rb_operand_i;
    logic  writeback_valid_o;
    xlen_t writeback_value_o;
    exc_e  writeback_exception_o;
    logic  stall_o;
    xlen_t mem_addr_o;
    xlen_t mem_data_wr_o;
    logic  mem_rd_o;
    strb_t mem_wr_o;
    logic  mem_accept_i;
    logic  mem_ack_i;
    logic  mem_error_i;
    xlen_t mem_data_rd_i;

    xlen_t shadow [256];
    xlen_t exp_value_q [$];
    exc_e  exp_exc_q [$];
    string exp_name_q [$];
    xlen_t touched_q [$];
    string test_name;
    string cmp_name;
    int    mismatch_count = 0;
    int    other_count = 0;
    int    issued_count = 0;
    int    cycle_count = 0;

    lsu_top dut0 (
        .clk_i                 (clk_i),
        .rst_i                 (rst_i),
        .opcode_valid_i        (opcode_valid_i),
        .opcode_opcode_i       (opcode_opcode_i),
        .opcode_ra_operand_i   (opcode_ra_operand_i),
        .opcode_rb_operand_i   (opcode_rb_operand_i),
        .writeback_valid_o     (writeback_valid_o),
        .writeback_value_o     (writeback_value_o),
        .writeback_exception_o (writeback_exception_o),
        .stall_o               (stall_o),
        .mem_addr_o            (mem_addr_o),
        .mem_data_wr_o         (mem_data_wr_o),
        .mem_rd_o              (mem_rd_o),
        .mem_wr_o              (mem_wr_o),
        .mem_accept_i          (mem_accept_i),
        .mem_ack_i             (mem_ack_i),
        .mem_error_i           (mem_error_i),
        .mem_data_rd_i         (mem_data_rd_i)
    );

    lsu_mem_model mem0 (
        .clk_i     (clk_i),
        .rst_i     (rst_i),
        .addr_i    (mem_addr_o),
        .data_wr_i (mem_data_wr_o),
        .rd_i      (mem_rd_o),
        .wr_i      (mem_wr_o),
        .accept_o  (mem_accept_i),
        .ack_o     (mem_ack_i),
        .error_o   (mem_error_i),
        .data_rd_o (mem_data_rd_i)
    );

    initial
    begin
        clk_i = 1'b0;
        forever #4 clk_i = ~clk_i;
    end

    // ----------------------------------------
    // Reference model
    // ----------------------------------------
    function automatic logic is_store(input lsu_op_e op);
        return (op == OP_SB) || (op == OP_SH) || (op == OP_SW);
    endfunction

    function automatic expect_t lsu_expect(input lsu_op_e op, input xlen_t addr,
                                           input xlen_t word);
        expect_t res;
        logic    mis;
        xlen_t   lane;
        res.value = '0;
        res.exc   = EXC_NONE;
        mis = ((op == OP_LW || op == OP_SW) && addr[1:0] != 2'b00)
            || ((op == OP_LH || op == OP_LHU || op == OP_SH) && addr[0]);
        lane = word >> (8 * addr[1:0]);
        if (mis)
        begin
            res.value = addr;
            res.exc   = is_store(op) ? EXC_MISALIGNED_STORE : EXC_MISALIGNED_LOAD;
        end
        else if (addr[31])
        begin
            res.value = addr;
            res.exc   = is_store(op) ? EXC_FAULT_STORE : EXC_FAULT_LOAD;
        end
        else
        begin
            case (op)
                OP_LB:   res.value = {{24{lane[7]}}, lane[7:0]};
                OP_LBU:  res.value = {24'd0, lane[7:0]};
                OP_LH:   res.value = {{16{lane[15]}}, lane[15:0]};
                OP_LHU:  res.value = {16'd0, lane[15:0]};
                OP_LW:   res.value = word;
                default: res.value = '0;
            endcase
        end
        return res;
    endfunction

    function automatic xlen_t merge_store(input lsu_op_e op, input xlen_t addr,
                                          input xlen_t rb, input xlen_t word);
        xlen_t res;
        res = word;
        case (op)
            OP_SB:   res[8*addr[1:0] +: 8] = rb[7:0];
            OP_SH:   res[16*addr[1] +: 16] = rb[15:0];
            default: res = rb;
        endcase
        return res;
    endfunction

    // ----------------------------------------
    // Stimulus helpers
    // ----------------------------------------
    function automatic xlen_t encode_instr(input lsu_op_e op, input logic [11:0] imm);
        reg_idx_t   rs1;
        reg_idx_t   rs2;
        reg_idx_t   rd;
        logic [2:0] f3;
        rs1 = 5'd2;
        rs2 = 5'd4;
        rd  = 5'd3;
        case (op)
            OP_LB, OP_SB: f3 = F3_B;
            OP_LH, OP_SH: f3 = F3_H;
            OP_LW, OP_SW: f3 = F3_W;
            OP_LBU:       f3 = F3_BU;
            default:      f3 = F3_HU;
        endcase
        if (is_store(op))
            return {imm[11:5], rs2, rs1, f3, imm[4:0], OPC_STORE};
        return {imm, rs1, f3, rd, OPC_LOAD};
    endfunction

    function automatic xlen_t word_addr();
        return {22'd0, 8'($urandom), 2'b00};
    endfunction

    function automatic lsu_op_e rand_op();
        case ($urandom_range(7, 0))
            0:       return OP_LB;
            1:       return OP_LBU;
            2:       return OP_LH;
            3:       return OP_LHU;
            4:       return OP_SB;
            5:       return OP_SH;
            6:       return OP_SW;
            default: return OP_LW;
        endcase
    endfunction

    // Present one access and hold it until the core would move on
    task automatic send(input lsu_op_e op, input xlen_t addr, input xlen_t rb,
                        input bit victim);
        logic [11:0] imm;
        xlen_t       word;
        expect_t     res;
        imm = 12'($urandom);
        opcode_valid_i      <= 1'b1;
        opcode_opcode_i     <= encode_instr(op, imm);
        opcode_ra_operand_i <= addr - {{20{imm[11]}}, imm};
        opcode_rb_operand_i <= rb;
        @(posedge clk_i);
        while (stall_o)
            @(posedge clk_i);
        issued_count++;
        // A squashed follower neither answers nor writes
        if (!victim)
        begin
            word = shadow[addr[9:2]];
            res  = lsu_expect(op, addr, word);
            exp_value_q.push_back(res.value);
            exp_exc_q.push_back(res.exc);
            exp_name_q.push_back(test_name);
            if (is_store(op) && res.exc == EXC_NONE)
                shadow[addr[9:2]] = merge_store(op, addr, rb, word);
        end
    endtask

    task automatic drain();
        opcode_valid_i <= 1'b0;
        while (exp_value_q.size() != 0)
            @(posedge clk_i);
        repeat (2) @(posedge clk_i);
        if (stall_o !== 1'b0)
        begin
            other_count++;
            $display("stall_o still high after all accesses retired in %s", test_name);
        end
    endtask

    // Trapping access, a store right behind it, then wait for the trap
    task automatic exception_pair(input lsu_op_e op, input xlen_t addr);
        xlen_t victim_addr;
        victim_addr = {22'd0, addr[9:2], 2'b00};
        send(op, addr, $urandom, 1'b0);
        send(OP_SW, victim_addr, $urandom, 1'b1);
        touched_q.push_back(victim_addr);
        drain();
    endtask

    task automatic verify_touched();
        while (touched_q.size() != 0)
            send(OP_LW, touched_q.pop_front(), '0, 1'b0);
        drain();
    endtask

    // ----------------------------------------
    // Compare and run control
    // ----------------------------------------
    task automatic check_value(input string name, input xlen_t exp_v, input xlen_t act_v);
        if (act_v !== exp_v)
        begin
            mismatch_count++;
            $display("MISMATCH %s value expected %h actual %h", name, exp_v, act_v);
        end
    endtask

    task automatic check_exc(input string name, input exc_e exp_e, input exc_e act_e);
        if (act_e !== exp_e)
        begin
            mismatch_count++;
            $display("MISMATCH %s exception expected %0d actual %0d", name, exp_e, act_e);
        end
    endtask

    task automatic close_run();
        $display("Error counts: %0d mismatches, %0d other failures",
                 mismatch_count, other_count);
        if (mismatch_count == 0 && other_count == 0)
            $display("TEST PASSED");
        else
            $display("TEST FAILED");
        $finish;
    endtask

    always @(negedge clk_i)
    begin
        if (!rst_i && writeback_valid_o)
        begin
            if (exp_value_q.size() == 0)
            begin
                other_count++;
                $display("Writeback of %h with no access waiting for a result",
                         writeback_value_o);
            end
            else
            begin
                cmp_name = exp_name_q.pop_front();
                check_value(cmp_name, exp_value_q.pop_front(), writeback_value_o);
                check_exc(cmp_name, exp_exc_q.pop_front(), writeback_exception_o);
            end
        end
    end

    always @(posedge clk_i)
    begin
        cycle_count++;
        if (cycle_count > 40 * issued_count + 200)
        begin
            other_count++;
            $display("Timeout after %0d cycles with %0d accesses issued",
                     cycle_count, issued_count);
            close_run();
        end
    end

    // ----------------------------------------
    // Test sequence
    // ----------------------------------------
    initial
    begin
        lsu_op_e op;
        xlen_t   addr;
        xlen_t   base;
        xlen_t   word_list [16];
        void'($urandom(76));
        rst_i               = 1'b1;
        opcode_valid_i      = 1'b0;
        opcode_opcode_i     = '0;
        opcode_ra_operand_i = '0;
        opcode_rb_operand_i = '0;
        test_name           = "reset";
        repeat (10) @(posedge clk_i);
        rst_i <= 1'b0;
        @(posedge clk_i);
        if (stall_o !== 1'b0 || mem_rd_o !== 1'b0 || mem_wr_o !== 4'b0000
            || writeback_valid_o !== 1'b0)
        begin
            other_count++;
            $display("Stall, request or writeback not low after reset");
        end
        for (int i = 0; i < 256; i++)
            shadow[i] = mem0.mem_q[i];

        test_name = "word_rw";
        for (int i = 0; i < 16; i++)
        begin
            word_list[i] = word_addr();
            send(OP_SW, word_list[i], $urandom, 1'b0);
        end
        for (int i = 0; i < 16; i++)
            send(OP_LW, word_list[i], '0, 1'b0);
        drain();

        test_name = "sub_word";
        for (int w = 0; w < 4; w++)
        begin
            base = word_addr();
            send(OP_SW, base, $urandom, 1'b0);
            for (int o = 0; o < 4; o++)
            begin
                send(OP_SB, base + o, $urandom, 1'b0);
                send(OP_LB, base + o, '0, 1'b0);
                send(OP_LBU, base + o, '0, 1'b0);
            end
            for (int o = 0; o < 4; o += 2)
            begin
                send(OP_SH, base + o, $urandom, 1'b0);
                send(OP_LH, base + o, '0, 1'b0);
                send(OP_LHU, base + o, '0, 1'b0);
            end
            send(OP_LW, base, '0, 1'b0);
        end
        drain();

        test_name = "misaligned";
        for (int o = 1; o < 4; o++)
        begin
            exception_pair(OP_LW, word_addr() + o);
            exception_pair(OP_SW, word_addr() + o);
        end
        for (int o = 1; o < 4; o += 2)
        begin
            exception_pair(OP_LH, word_addr() + o);
            exception_pair(OP_LHU, word_addr() + o);
            exception_pair(OP_SH, word_addr() + o);
        end
        verify_touched();

        test_name = "bus_fault";
        base = {1'b1, 21'($urandom), 8'($urandom), 2'b00};
        exception_pair(OP_LB, base + 1);
        exception_pair(OP_LBU, base + 3);
        exception_pair(OP_LH, base + 2);
        exception_pair(OP_LHU, base);
        exception_pair(OP_LW, base);
        exception_pair(OP_SB, base + 2);
        exception_pair(OP_SH, base + 2);
        exception_pair(OP_SW, base);
        verify_touched();

        test_name = "stream";
        for (int i = 0; i < 60; i++)
        begin
            op   = rand_op();
            addr = word_addr();
            case (op)
                OP_LB, OP_LBU, OP_SB: addr[1:0] = 2'($urandom);
                OP_LH, OP_LHU, OP_SH: addr[1] = 1'($urandom);
                default:              addr[1:0] = 2'b00;
            endcase
            send(op, addr, $urandom, 1'b0);
        end
        drain();

        close_run();
    end

endmodule

`default_nettype wire

// File: compile.f
logic/lsu_pkg.sv
logic/lsu_req_if.sv
logic/lsu_tag_if.sv
logic/lsu_decode.sv
logic/lsu_issue.sv
logic/lsu_tag_fifo.sv
logic/lsu_resp.sv
logic/lsu_top.sv
bench/lsu_mem_model.sv
bench/tb_lsu.sv

// File: Bender.yml
package:
  name: lsu

sources:
  - files:
      - logic/lsu_pkg.sv
      - logic/lsu_req_if.sv
      - logic/lsu_tag_if.sv
      - logic/lsu_decode.sv
      - logic/lsu_issue.sv
      - logic/lsu_tag_fifo.sv
      - logic/lsu_resp.sv
      - logic/lsu_top.sv
  - target: test
    files:
      - bench/lsu_mem_model.sv
      - bench/tb_lsu.sv
